// File: bus_proto_pkg.sv
//**************************************************************************
// Bus protocol definitions: frame widths, acknowledge prefixes, guard and
// timeout limits, and the packed structs for the bus-side port signals
//**************************************************************************
package bus_proto_pkg;

    localparam int ADDR_W   = 12;
    localparam int DATA_W   = 8;
    localparam int TIMER_W  = 6;
    localparam int BITCNT_W = $clog2(ADDR_W + 1);   // holds a full address count

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TIMER_W-1:0]  tmr_t;
    typedef logic [BITCNT_W-1:0] bitcnt_t;

    localparam tmr_t GUARD_CYCLES = tmr_t'(8);      // grant hold before address
    localparam tmr_t ACK_TIMEOUT  = tmr_t'(32);     // address ack window

    localparam bitcnt_t ADDR_BITS = bitcnt_t'(ADDR_W);
    localparam bitcnt_t DATA_BITS = bitcnt_t'(DATA_W);

    localparam logic [1:0] ADDR_ACK_PREFIX = 2'b00;
    localparam logic [1:0] DATA_PREFIX     = 2'b01; // write ack and read start

    typedef struct packed {
        logic request;
        logic util;
        logic rw;
        logic sd_oe;
        logic sd_out;
        logic rw_oe;
    } bus_out_t;

    typedef struct packed {
        logic grant;
        logic sd_in;
    } bus_in_t;

endpackage

// File: master_pkg.sv
//**************************************************************************
// Master host-side types: command and response structs, control FSM states
//**************************************************************************
package master_pkg;

    typedef struct packed {
        logic                 write;      // 1 write, 0 read
        bus_proto_pkg::addr_t addr;
        bus_proto_pkg::data_t wdata;
    } host_cmd_t;

    typedef struct packed {
        bus_proto_pkg::data_t rdata;
    } host_rsp_t;

    typedef enum logic [3:0] {
        IDLE,
        REQUEST,      // bus requested, no grant yet
        GUARD,        // grant must hold before the address
        ADDR_SEND,
        ADDR_ACK,
        WRITE_SEND,
        WRITE_ACK,
        READ_START,
        READ_DATA,
        HOST_DONE     // host_ack high until host_req falls
    } ctrl_state_t;

endpackage

// File: wait_timer.sv
//**************************************************************************
// Shared cycle timer for the grant guard time and the address ack timeout
//**************************************************************************
`timescale 1ns/1ps

module wait_timer (
    input  logic clk,
    input  logic rstn,
    input  logic start,      // clears the count
    input  logic run,        // count enable
    input  logic sel,        // 0 guard limit, 1 timeout limit
    output logic expired
);

    bus_proto_pkg::tmr_t count;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            count <= '0;
        end
        else if (start)
        begin
            count <= '0;
        end
        else if (run)
        begin
            count <= count + 1'b1;
        end
    end

    assign expired = sel ? (count == bus_proto_pkg::ACK_TIMEOUT)
                         : (count == bus_proto_pkg::GUARD_CYCLES);

endmodule

// File: serial_tx.sv
//**************************************************************************
// Serial transmit path: loads an address or data word and shifts it out
// MSB first, one bit per cycle, with output enable and a last-bit pulse
//**************************************************************************
`timescale 1ns/1ps

module serial_tx (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 load,
    input  logic                 is_addr,
    input  bus_proto_pkg::addr_t addr,
    input  bus_proto_pkg::data_t data,
    output logic                 sd_out,
    output logic                 sd_oe,
    output logic                 done
);

    localparam int PAD_W = bus_proto_pkg::ADDR_W - bus_proto_pkg::DATA_W;

    bus_proto_pkg::addr_t   shreg;   // data words sit in the upper bits
    bus_proto_pkg::bitcnt_t bits_left;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bits_left <= '0;
        end
        else if (load)
        begin
            bits_left <= is_addr ? bus_proto_pkg::ADDR_BITS : bus_proto_pkg::DATA_BITS;
        end
        else if (bits_left != '0)
        begin
            bits_left <= bits_left - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            shreg <= is_addr ? addr : {data, {PAD_W{1'b0}}};
        end
        else if (bits_left != '0)
        begin
            shreg <= {shreg[bus_proto_pkg::ADDR_W-2:0], 1'b0};
        end
    end

    assign sd_oe  = (bits_left != '0);
    assign sd_out = sd_oe ? shreg[bus_proto_pkg::ADDR_W-1] : 1'b1;   // idle high
    assign done   = (bits_left == bus_proto_pkg::bitcnt_t'(1));

endmodule

// File: serial_rx.sv
//**************************************************************************
// Serial receive path: two-bit prefix detection on the line and a
// DATA_W bit shift-in for read data, MSB first
//**************************************************************************
`timescale 1ns/1ps

module serial_rx (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 sd_in,
    input  logic                 arm,          // prefix detection enable
    input  logic                 capture,      // start of read data shift-in
    output logic                 ack_seen,
    output logic                 start_seen,
    output logic                 word_valid,
    output bus_proto_pkg::data_t word
);

    logic                   prev_bit;
    logic                   prefix_hit;
    bus_proto_pkg::data_t   shreg;
    bus_proto_pkg::bitcnt_t bits_left;

    assign ack_seen   = arm && ({prev_bit, sd_in} == bus_proto_pkg::ADDR_ACK_PREFIX);
    assign start_seen = arm && ({prev_bit, sd_in} == bus_proto_pkg::DATA_PREFIX);
    assign prefix_hit = ack_seen || start_seen;

    // a consumed prefix must not lend its last bit to the next search
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            prev_bit <= 1'b1;
        end
        else if (!arm || prefix_hit)
        begin
            prev_bit <= 1'b1;
        end
        else
        begin
            prev_bit <= sd_in;
        end
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            bits_left <= '0;
        end
        else if (capture)
        begin
            bits_left <= bus_proto_pkg::DATA_BITS;
        end
        else if (bits_left != '0)
        begin
            bits_left <= bits_left - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bits_left != '0)
        begin
            shreg <= {shreg[bus_proto_pkg::DATA_W-2:0], sd_in};
        end
    end

    // last bit is taken straight from the line
    assign word_valid = (bits_left == bus_proto_pkg::bitcnt_t'(1));
    assign word       = {shreg[bus_proto_pkg::DATA_W-2:0], sd_in};

endmodule

// File: master_ctrl.sv
//**************************************************************************
// Bus master control FSM: host handshake, bus request and guard time,
// address frame with ack timeout and resend, write and read data phases
//**************************************************************************
`timescale 1ns/1ps

module master_ctrl (
    input  logic                   clk,
    input  logic                   rstn,
    // host side
    input  logic                   host_req,
    input  master_pkg::host_cmd_t  host_cmd,
    output logic                   host_ack,
    output master_pkg::host_rsp_t  host_rsp,
    // arbiter side
    input  logic                   grant,
    output logic                   request,
    output logic                   util,
    output logic                   rw,
    // timer
    output logic                   tmr_start,
    output logic                   tmr_run,
    output logic                   tmr_sel,
    input  logic                   tmr_expired,
    // transmit path
    output logic                   tx_load,
    output logic                   tx_is_addr,
    output bus_proto_pkg::addr_t   tx_addr,
    output bus_proto_pkg::data_t   tx_data,
    input  logic                   tx_done,
    // receive path
    output logic                   rx_arm,
    output logic                   rx_capture,
    input  logic                   rx_ack_seen,
    input  logic                   rx_start_seen,
    input  logic                   rx_word_valid,
    input  bus_proto_pkg::data_t   rx_word
);

    master_pkg::ctrl_state_t state;
    master_pkg::ctrl_state_t state_nxt;
    master_pkg::host_cmd_t   cmd_q;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= master_pkg::IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == master_pkg::IDLE && host_req)
        begin
            cmd_q <= host_cmd;                      // held for the whole transaction
        end
        if (state == master_pkg::READ_DATA && rx_word_valid)
        begin
            host_rsp.rdata <= rx_word;
        end
    end

    always_comb
    begin
        state_nxt  = state;
        tmr_start  = 1'b0;
        tmr_run    = 1'b0;
        tx_load    = 1'b0;
        rx_capture = 1'b0;
        case (state)
            master_pkg::IDLE:
            begin
                tmr_start = 1'b1;
                if (host_req)
                begin
                    state_nxt = master_pkg::REQUEST;
                end
            end
            master_pkg::REQUEST, master_pkg::GUARD:
            begin
                // guard count runs only over consecutive granted cycles
                tmr_start = !grant;
                tmr_run   = grant;
                if (state == master_pkg::REQUEST && grant)
                begin
                    state_nxt = master_pkg::GUARD;
                end
                else if (state == master_pkg::GUARD && tmr_expired)
                begin
                    tx_load   = 1'b1;
                    state_nxt = master_pkg::ADDR_SEND;
                end
            end
            master_pkg::ADDR_SEND:
            begin
                if (tx_done)
                begin
                    tmr_start = 1'b1;               // ack window opens
                    state_nxt = master_pkg::ADDR_ACK;
                end
            end
            master_pkg::ADDR_ACK:
            begin
                tmr_run = 1'b1;
                if (rx_ack_seen)
                begin
                    tx_load   = cmd_q.write;
                    state_nxt = cmd_q.write ? master_pkg::WRITE_SEND : master_pkg::READ_START;
                end
                else if (tmr_expired)
                begin
                    tmr_start = 1'b1;               // fresh guard, then resend
                    state_nxt = master_pkg::GUARD;
                end
            end
            master_pkg::WRITE_SEND:
            begin
                if (tx_done)
                begin
                    state_nxt = master_pkg::WRITE_ACK;
                end
            end
            master_pkg::WRITE_ACK:
            begin
                if (rx_start_seen)
                begin
                    state_nxt = master_pkg::HOST_DONE;
                end
            end
            master_pkg::READ_START:
            begin
                if (rx_start_seen)
                begin
                    rx_capture = 1'b1;
                    state_nxt  = master_pkg::READ_DATA;
                end
            end
            master_pkg::READ_DATA:
            begin
                if (rx_word_valid)
                begin
                    state_nxt = master_pkg::HOST_DONE;
                end
            end
            master_pkg::HOST_DONE:
            begin
                if (!host_req)
                begin
                    state_nxt = master_pkg::IDLE;
                end
            end
            default:
            begin
                state_nxt = master_pkg::IDLE;
            end
        endcase
    end

    assign host_ack   = (state == master_pkg::HOST_DONE);
    assign request    = (state != master_pkg::IDLE);
    assign util       = request && (state != master_pkg::REQUEST);
    assign rw         = util && cmd_q.write;
    assign tmr_sel    = (state == master_pkg::ADDR_ACK);
    assign tx_is_addr = (state == master_pkg::GUARD);
    assign tx_addr    = cmd_q.addr;
    assign tx_data    = cmd_q.wdata;
    assign rx_arm     = (state == master_pkg::ADDR_ACK) || (state == master_pkg::WRITE_ACK)
                     || (state == master_pkg::READ_START);

endmodule

// File: bus_master.sv
//**************************************************************************
// Bus master top: control FSM with timer, transmit and receive paths
//**************************************************************************
`timescale 1ns/1ps

module bus_master (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   host_req,
    input  master_pkg::host_cmd_t  host_cmd,
    output logic                   host_ack,
    output master_pkg::host_rsp_t  host_rsp,
    input  bus_proto_pkg::bus_in_t bus_in,
    output bus_proto_pkg::bus_out_t bus_out
);

    logic                 request;
    logic                 util;
    logic                 rw;
    logic                 tmr_start;
    logic                 tmr_run;
    logic                 tmr_sel;
    logic                 tmr_expired;
    logic                 tx_load;
    logic                 tx_is_addr;
    logic                 tx_done;
    logic                 sd_out;
    logic                 sd_oe;
    logic                 rx_arm;
    logic                 rx_capture;
    logic                 rx_ack_seen;
    logic                 rx_start_seen;
    logic                 rx_word_valid;
    bus_proto_pkg::addr_t tx_addr;
    bus_proto_pkg::data_t tx_data;
    bus_proto_pkg::data_t rx_word;

    master_ctrl u_ctrl (
        .clk,
        .rstn,
        .host_req,
        .host_cmd,
        .host_ack,
        .host_rsp,
        .grant         (bus_in.grant),
        .request,
        .util,
        .rw,
        .tmr_start,
        .tmr_run,
        .tmr_sel,
        .tmr_expired,
        .tx_load,
        .tx_is_addr,
        .tx_addr,
        .tx_data,
        .tx_done,
        .rx_arm,
        .rx_capture,
        .rx_ack_seen,
        .rx_start_seen,
        .rx_word_valid,
        .rx_word
    );

    wait_timer u_timer (
        .clk,
        .rstn,
        .start   (tmr_start),
        .run     (tmr_run),
        .sel     (tmr_sel),
        .expired (tmr_expired)
    );

    serial_tx u_tx (
        .clk,
        .rstn,
        .load    (tx_load),
        .is_addr (tx_is_addr),
        .addr    (tx_addr),
        .data    (tx_data),
        .sd_out,
        .sd_oe,
        .done    (tx_done)
    );

    serial_rx u_rx (
        .clk,
        .rstn,
        .sd_in      (bus_in.sd_in),
        .arm        (rx_arm),
        .capture    (rx_capture),
        .ack_seen   (rx_ack_seen),
        .start_seen (rx_start_seen),
        .word_valid (rx_word_valid),
        .word       (rx_word)
    );

    assign bus_out.request = request;
    assign bus_out.util    = util;
    assign bus_out.rw      = rw;
    assign bus_out.sd_oe   = sd_oe;
    assign bus_out.sd_out  = sd_out;
    assign bus_out.rw_oe   = util;          // rw is driven while the bus is owned

endmodule

// File: tb_checker.sv
//**************************************************************************
// Bus master checker: rebuilds serial frames from the DUT ports, checks
// guard and retry timing, bus ownership, handshake order, read data
//**************************************************************************
`timescale 1ns/1ps

module tb_checker (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    host_req,
    input  logic                    host_ack,
    input  master_pkg::host_rsp_t   host_rsp,
    input  bus_proto_pkg::bus_in_t  bus_in,
    input  bus_proto_pkg::bus_out_t bus_out,
    input  logic                    exp_load,
    input  master_pkg::host_cmd_t   exp_cmd,
    input  bus_proto_pkg::data_t    exp_rdata,
    input  int                      exp_drops,
    output int                      errors,
    output int                      checked
);

    master_pkg::host_cmd_t cmd;
    bus_proto_pkg::data_t  rdata;
    logic [15:0]           shift;
    int                    err_cnt = 0;
    int                    done_cnt = 0;
    int                    drops = 0;
    int                    addr_frames = 0;
    int                    data_frames = 0;
    int                    nbits = 0;
    int                    cyc = 0;
    int                    grant_cyc = 0;
    int                    end_cyc = 0;
    logic                  active = 1'b0;
    logic                  wack_seen = 1'b0;
    logic                  req_q = 1'b0;
    logic                  req_qq = 1'b0;
    logic                  ack_q = 1'b0;
    logic                  request_q = 1'b0;
    logic                  grant_q = 1'b0;
    logic                  owned_q = 1'b0;
    logic                  oe_q = 1'b0;
    logic                  sd_in_q = 1'b1;

    assign errors  = err_cnt;
    assign checked = done_cnt;

    task flag(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task frame_start;
        shift = '0;
        nbits = 0;
        if (!active)
            flag("line driven outside a transaction");
        if (addr_frames == 0 && cyc - grant_cyc != int'(bus_proto_pkg::GUARD_CYCLES) + 1)
            flag($sformatf("address frame started %0d cycles after grant", cyc - grant_cyc));
        if (addr_frames > 0 && addr_frames <= drops
            && cyc - end_cyc < int'(bus_proto_pkg::ACK_TIMEOUT) + int'(bus_proto_pkg::GUARD_CYCLES))
            flag($sformatf("address resent after only %0d silent cycles", cyc - end_cyc));
        if (addr_frames > drops && !cmd.write)
            flag("master drove the line during a read");
    endtask

    task frame_end;
        end_cyc = cyc;
        if (addr_frames <= drops)
        begin
            if (nbits != bus_proto_pkg::ADDR_W || shift[bus_proto_pkg::ADDR_W-1:0] != cmd.addr)
                flag($sformatf("address frame %h with %0d bits, expected %h",
                               shift[bus_proto_pkg::ADDR_W-1:0], nbits, cmd.addr));
            addr_frames++;
        end
        else
        begin
            if (nbits != bus_proto_pkg::DATA_W || shift[bus_proto_pkg::DATA_W-1:0] != cmd.wdata)
                flag($sformatf("data frame %h with %0d bits, expected %h",
                               shift[bus_proto_pkg::DATA_W-1:0], nbits, cmd.wdata));
            data_frames++;
        end
    endtask

    task check_done;
        if (!active)
            flag("host_ack without a command");
        if (addr_frames != drops + 1)
            flag($sformatf("%0d address frames, expected %0d", addr_frames, drops + 1));
        if (cmd.write && (data_frames != 1 || !wack_seen))
            flag("write acknowledged to the host before data frame and 01 prefix");
        if (!cmd.write && host_rsp.rdata !== rdata)
            flag($sformatf("read data %h, expected %h", host_rsp.rdata, rdata));
        done_cnt++;
        active = 1'b0;
    endtask

    always @(negedge clk)
    begin
        if (!rstn)
        begin
            if (host_ack || bus_out.request || bus_out.sd_oe)
                flag("outputs not idle during reset");
        end
        else
        begin
            cyc++;
            if (exp_load)
            begin
                cmd         = exp_cmd;
                rdata       = exp_rdata;
                drops       = exp_drops;
                addr_frames = 0;
                data_frames = 0;
                wack_seen   = 1'b0;
                active      = 1'b1;
            end
            if ((bus_out.request && !request_q) != (req_q && !req_qq))
                flag("request did not rise one cycle after host_req");
            if (!bus_out.request && (host_ack || bus_out.sd_oe))
                flag("host_ack or line drive without a bus request");
            if (ack_q && !host_ack && req_q)
                flag("host_ack fell while host_req was still high");
            if ((request_q && !bus_out.request) != (ack_q && !host_ack))
                flag("request and host_ack did not fall together");
            if (bus_out.util !== (bus_out.request && owned_q) || bus_out.rw_oe !== bus_out.util)
                flag("util or rw_oe does not follow the grant");
            if (bus_out.util && bus_out.rw !== cmd.write)
                flag("rw differs from the command while the bus is owned");
            if (bus_in.grant && !grant_q)
                grant_cyc = cyc;                    // guard restarts on every rise
            if (host_ack && !ack_q)
                check_done();
            if (bus_out.sd_oe)
            begin
                if (!oe_q)
                    frame_start();
                shift = {shift[14:0], bus_out.sd_out};
                nbits++;
            end
            else if (oe_q)
            begin
                frame_end();
            end
            else if (data_frames > 0 && cmd.write && !sd_in_q && bus_in.sd_in)
            begin
                wack_seen = 1'b1;                   // slave's 01 after write data
            end
        end
        req_qq    = req_q;
        req_q     = host_req;
        ack_q     = host_ack;
        request_q = bus_out.request;
        grant_q   = bus_in.grant;
        owned_q   = bus_out.request && (owned_q || bus_in.grant);   // owned from the grant on
        oe_q      = bus_out.sd_oe;
        sd_in_q   = bus_in.sd_in;
    end

endmodule

// File: tb_bus_master.sv
//**************************************************************************
// Bus master testbench top: clock and reset, host driver, arbiter and
// slave model playing the commands of bus_patterns.txt, checker hookup
//**************************************************************************
`timescale 1ns/1ps

module tb_bus_master;

    typedef enum int {SIG_REQUEST, SIG_SD_OE, SIG_HOST_ACK} watch_t;

    logic                    clk;
    logic                    rstn;
    logic                    host_req;
    master_pkg::host_cmd_t   host_cmd;
    logic                    host_ack;
    master_pkg::host_rsp_t   host_rsp;
    bus_proto_pkg::bus_in_t  bus_in;
    bus_proto_pkg::bus_out_t bus_out;
    logic                    exp_load;
    master_pkg::host_cmd_t   exp_cmd;
    bus_proto_pkg::data_t    exp_rdata;
    int                      exp_drops;
    int                      errors;
    int                      checked;
    integer                  seed;
    integer                  fd;
    int                      n_cmds;

    bus_master i_dut (
        .clk,
        .rstn,
        .host_req,
        .host_cmd,
        .host_ack,
        .host_rsp,
        .bus_in,
        .bus_out
    );

    tb_checker u_checker (
        .clk,
        .rstn,
        .host_req,
        .host_ack,
        .host_rsp,
        .bus_in,
        .bus_out,
        .exp_load,
        .exp_cmd,
        .exp_rdata,
        .exp_drops,
        .errors,
        .checked
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                      // 8 ns period
    end

    function automatic logic probe(input watch_t sel);
        case (sel)
            SIG_REQUEST: return bus_out.request;
            SIG_SD_OE:   return bus_out.sd_oe;
            default:     return host_ack;
        endcase
    endfunction

    task automatic wait_for(input watch_t sel, input logic level, input int limit,
                            input string stage);
        int n;
        n = 0;
        while (probe(sel) !== level && n < limit)
        begin
            @(posedge clk);
            n++;
        end
        if (probe(sel) !== level)
        begin
            $display("timeout at %0t while waiting for %s", $time, stage);
            $display("TEST FAILED");
            $finish;
        end
    endtask

    // slave drives bits MSB first, then lets the line idle high
    task automatic drive_line(input logic [9:0] bits, input int n);
        for (int i = n - 1; i >= 0; i--)
        begin
            @(posedge clk);
            bus_in.sd_in <= bits[i];
        end
        @(posedge clk);
        bus_in.sd_in <= 1'b1;
    endtask

    task automatic run_command(input master_pkg::host_cmd_t cmd, input int gdelay,
                               input int drops, input int idx);
        bus_proto_pkg::data_t rdata;
        int                   frame_wait;
        rdata      = bus_proto_pkg::data_t'($random(seed));
        frame_wait = int'(bus_proto_pkg::ACK_TIMEOUT) + int'(bus_proto_pkg::GUARD_CYCLES) + 24;
        @(posedge clk);
        exp_cmd   <= cmd;
        exp_rdata <= rdata;
        exp_drops <= drops;
        exp_load  <= 1'b1;
        @(posedge clk);
        exp_load <= 1'b0;
        host_cmd <= cmd;
        host_req <= 1'b1;
        wait_for(SIG_REQUEST, 1'b1, 4, "bus request");
        repeat (gdelay) @(posedge clk);
        bus_in.grant <= 1'b1;
        if (idx % 2 == 1)
        begin
            repeat (3) @(posedge clk);              // brief grant drop inside the guard
            bus_in.grant <= 1'b0;
            @(posedge clk);
            bus_in.grant <= 1'b1;
        end
        for (int k = 0; k <= drops; k++)            // slave stays silent on the first drops
        begin
            wait_for(SIG_SD_OE, 1'b1, frame_wait, "address frame start");
            wait_for(SIG_SD_OE, 1'b0, bus_proto_pkg::ADDR_W + 2, "address frame end");
        end
        @(posedge clk);
        drive_line(10'b00, 2);                      // address ack
        if (cmd.write)
        begin
            wait_for(SIG_SD_OE, 1'b1, 4, "write data frame start");
            wait_for(SIG_SD_OE, 1'b0, bus_proto_pkg::DATA_W + 2, "write data frame end");
            repeat (2) @(posedge clk);
            drive_line(10'b01, 2);                  // write ack
        end
        else
        begin
            repeat (2) @(posedge clk);
            drive_line({2'b01, rdata}, 10);         // read start and data
        end
        wait_for(SIG_HOST_ACK, 1'b1, 8, "host_ack rise");
        repeat (idx % 3) @(posedge clk);            // host holds the handshake a while
        host_req <= 1'b0;
        wait_for(SIG_HOST_ACK, 1'b0, 4, "host_ack fall");
        bus_in.grant <= 1'b0;                       // arbiter follows the request
    endtask

    initial
    begin
        string                 line;
        int                    got;
        int                    fields;
        int                    op;
        int                    gdelay;
        int                    drops;
        logic [31:0]           addr_v;
        logic [31:0]           data_v;
        master_pkg::host_cmd_t cmd;
        seed         = 32'hbac8a840;
        n_cmds       = 0;
        rstn         = 1'b0;
        host_req     = 1'b0;
        host_cmd     = '0;
        bus_in.grant = 1'b0;
        bus_in.sd_in = 1'b1;
        exp_load     = 1'b0;
        exp_cmd      = '0;
        exp_rdata    = '0;
        exp_drops    = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        fd = $fopen("bus_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bus_patterns.txt");
            $display("TEST FAILED");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line.len() > 0 && line[0] != "#")
                begin
                    fields = $sscanf(line, "%d %h %h %d %d", op, addr_v, data_v, gdelay, drops);
                    if (fields == 5)
                    begin
                        cmd.write = op[0];
                        cmd.addr  = addr_v[bus_proto_pkg::ADDR_W-1:0];
                        cmd.wdata = data_v[bus_proto_pkg::DATA_W-1:0];
                        run_command(cmd, gdelay, drops, n_cmds);
                        n_cmds++;
                    end
                end
            end
            $fclose(fd);
            repeat (4) @(posedge clk);
            $display("errors: %0d, transactions checked: %0d of %0d", errors, checked, n_cmds);
            if (errors == 0 && checked == n_cmds && n_cmds > 0)
            begin
                $display("TEST OK");
            end
            else
            begin
                if (checked != n_cmds || n_cmds == 0)
                    $display("checker did not see every command complete");
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

// File: bus_patterns.txt
# op (1 write, 0 read)  addr (hex)  wdata (hex)  grant delay (cycles)  dropped address acks
# wdata is ignored for reads; every second command also sees a short grant drop in its guard
1 a5c 3c 0 0
0 a5c 00 2 0
1 fff ff 5 0
0 000 00 0 1
1 123 81 1 1
0 800 00 7 0
1 001 00 3 2
0 7e4 00 0 2
1 555 aa 9 0
0 2b7 00 4 1
1 c0d e5 0 0
0 3f0 00 6 0
1 6a9 5a 2 1
0 fff 00 1 0

// File: build.f
bus_proto_pkg.sv
master_pkg.sv
wait_timer.sv
serial_tx.sv
serial_rx.sv
master_ctrl.sv
bus_master.sv
tb_checker.sv
tb_bus_master.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_bus_master
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
